// File: logic/synth_pkg.sv
`default_nettype none

package synth_pkg;

	// note number, 0 is a rest
	// 1..63 climb one semitone each
	typedef logic [5:0] note_t;

	// waveform kinds a tone channel can be built as
	typedef enum logic {
		wave_square,
		wave_triangle
	} wave_e;

	// one channel amplitude, 0..15
	typedef logic [3:0] level_t;

	// mixed audio sample
	typedef logic [7:0] sample_t;

	// volume as a left shift of each level
	typedef logic [1:0] vol_t;

	// what one channel plays during a step
	typedef struct packed {
		note_t note;
		logic  gate;
	} chan_cmd_t;

	// half periods in clock cycles for notes 1..12
	// each entry is the one before divided by the twelfth root of two
	localparam logic [15:0] BASE_HALF_PERIOD [12] = '{
		16'd1024, 16'd967, 16'd912, 16'd861, 16'd813, 16'd767,
		16'd724, 16'd683, 16'd645, 16'd609, 16'd575, 16'd542
	};

	// half period of a note
	// semitone picks the entry, every octave up halves it
	function automatic logic [15:0] note_half_period(note_t note);
		logic [5:0] idx;
		logic [5:0] semi;
		logic [5:0] octave;
		idx = note - 6'd1;
		semi = idx % 6'd12;
		octave = idx / 6'd12;
		return BASE_HALF_PERIOD[semi[3:0]] >> octave;
	endfunction

endpackage

`default_nettype wire

// File: logic/seq_pkg.sv
`default_nettype none

package seq_pkg;

	// sequencer FSM states
	typedef enum logic [1:0] {
		seq_idle,
		seq_play,
		seq_hold
	} seq_state_e;

	// pattern length
	localparam int NUM_STEPS = 16;
	typedef logic [$clog2(NUM_STEPS)-1:0] step_idx_t;

	// clock cycles per step, kept short for simulation
	localparam int STEP_TICKS = 2048;
	localparam int TICK_W = $clog2(STEP_TICKS);
	typedef logic [TICK_W-1:0] tick_cnt_t;

	// steady reload of the tempo counter
	localparam tick_cnt_t TICK_RELOAD = tick_cnt_t'(STEP_TICKS - 1);
	// start value after a clear, one lower to cover the load cycle
	localparam tick_cnt_t TICK_START = tick_cnt_t'(STEP_TICKS - 2);

	// commands for all three channels in one step
	// ch0 lead square, ch1 bass square, ch2 triangle
	typedef struct packed {
		synth_pkg::chan_cmd_t ch2;
		synth_pkg::chan_cmd_t ch1;
		synth_pkg::chan_cmd_t ch0;
	} step_rec_t;

endpackage

`default_nettype wire

// File: logic/tempo_timer.sv
`timescale 1ns/1ns
`default_nettype none

module tempo_timer (
	input wire logic clk,
	input wire logic rst,
	input wire logic en,
	input wire logic clear,
	output logic tick
);
	import seq_pkg::*;

	tick_cnt_t count;

	// down counter, frozen while en is low
	always_ff @(posedge clk)
	begin
		if (rst || clear)
		begin
			count <= TICK_START;
			tick <= 1'b0;
		end
		else if (en)
		begin
			// expiry gives one tick and a fresh step
			tick <= (count == '0);
			count <= (count == '0) ? TICK_RELOAD : count - 1'b1;
		end
		else
		begin
			tick <= 1'b0;
		end
	end

	// tick is a strobe, never two cycles in a row
	assert property (@(posedge clk) disable iff (rst) tick |=> !tick)
		else $error("tempo tick high for two cycles");

endmodule

`default_nettype wire

// File: logic/pattern_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module pattern_sequencer (
	input wire logic clk,
	input wire logic rst,
	input wire logic run,
	input wire logic pause,
	input wire logic restart,
	input wire logic tick,
	output logic timer_en,
	output logic timer_clear,
	output seq_pkg::step_rec_t step,
	output seq_pkg::step_idx_t step_idx,
	output logic step_strobe
);
	import synth_pkg::*;
	import seq_pkg::*;

	// lead melody, odd steps rest
	localparam note_t LEAD_NOTES [NUM_STEPS] = '{
		6'd41, 6'd0, 6'd46, 6'd0, 6'd44, 6'd0, 6'd37, 6'd0,
		6'd37, 6'd0, 6'd39, 6'd0, 6'd39, 6'd0, 6'd51, 6'd0
	};
	// bass alternates octaves every two steps
	localparam note_t BASS_NOTES [NUM_STEPS] = '{
		6'd1, 6'd1, 6'd13, 6'd13, 6'd1, 6'd1, 6'd13, 6'd13,
		6'd1, 6'd1, 6'd13, 6'd13, 6'd1, 6'd1, 6'd13, 6'd13
	};
	// triangle arpeggio over three octaves
	localparam note_t TRI_NOTES [NUM_STEPS] = '{
		6'd1, 6'd13, 6'd25, 6'd1, 6'd13, 6'd25, 6'd1, 6'd13,
		6'd25, 6'd1, 6'd13, 6'd25, 6'd1, 6'd13, 6'd25, 6'd1
	};

	seq_state_e state;
	seq_state_e state_next;
	step_idx_t next_idx;
	step_idx_t load_idx;
	logic load;

	// record for one pattern position
	function automatic step_rec_t pattern_rec(step_idx_t idx);
		step_rec_t rec;
		rec.ch0.note = LEAD_NOTES[idx];
		// lead only sounds on even steps
		rec.ch0.gate = ~idx[0];
		rec.ch1.note = BASS_NOTES[idx];
		rec.ch1.gate = 1'b1;
		rec.ch2.note = TRI_NOTES[idx];
		rec.ch2.gate = 1'b1;
		return rec;
	endfunction

	// wrap after the last step
	assign next_idx = (step_idx == step_idx_t'(NUM_STEPS - 1)) ? '0 : step_idx + 1'b1;

	// timer runs only in play
	assign timer_en = (state == seq_play);
	// start of play or a restart both go back to step 0
	assign timer_clear = run && ((state == seq_idle) || restart);
	// a tick outside play is dropped
	assign load = timer_clear || (run && (state == seq_play) && tick);
	assign load_idx = timer_clear ? '0 : next_idx;

	always_comb
	begin
		if (!run)
			state_next = seq_idle;
		else if (state == seq_idle)
			state_next = seq_play;
		else
			state_next = pause ? seq_hold : seq_play;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= seq_idle;
			step <= '0;
			step_idx <= '0;
			step_strobe <= 1'b0;
		end
		else
		begin
			state <= state_next;
			step_strobe <= load;
			if (load)
			begin
				step_idx <= load_idx;
				step <= pattern_rec(load_idx);
			end
			else if (state_next == seq_idle)
			begin
				// stopped, all channels silent
				step <= '0;
			end
		end
	end

	// hold keeps the index unless restarted
	assert property (@(posedge clk) disable iff (rst)
		(state == seq_hold && !timer_clear) |=> $stable(step_idx))
		else $error("step index moved during hold");

	// the table never gates a rest
	assert property (@(posedge clk) disable iff (rst)
		!(step.ch0.gate && step.ch0.note == '0) &&
		!(step.ch1.gate && step.ch1.note == '0) &&
		!(step.ch2.gate && step.ch2.note == '0))
		else $error("gate set on a rest note");

endmodule

`default_nettype wire

// File: logic/tone_channel.sv
`timescale 1ns/1ns
`default_nettype none

module tone_channel #(
	parameter synth_pkg::wave_e WAVE = synth_pkg::wave_square
) (
	input wire logic clk,
	input wire logic rst,
	input wire synth_pkg::chan_cmd_t cmd,
	output synth_pkg::level_t level
);
	import synth_pkg::*;

	logic [15:0] reload;
	logic [15:0] phase;
	note_t note_q;
	logic active;
	logic expire;
	logic sq_hi;
	level_t ramp;
	logic ramp_up;

	// a rest is silent even with the gate set
	assign active = cmd.gate && (cmd.note != '0);
	assign expire = (phase == '0);

	// triangle steps sixteen times per half period
	always_comb
	begin
		if (WAVE == wave_triangle)
			reload = note_half_period(cmd.note) >> 4;
		else
			reload = note_half_period(cmd.note);
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			phase <= '0;
			note_q <= '0;
			sq_hi <= 1'b0;
			ramp <= '0;
			ramp_up <= 1'b1;
		end
		else if (!active || cmd.note != note_q)
		begin
			// new note or silence restarts the cycle
			phase <= reload - 16'd1;
			note_q <= cmd.note;
			sq_hi <= 1'b0;
			if (!active)
			begin
				ramp <= '0;
				ramp_up <= 1'b1;
			end
		end
		else if (expire)
		begin
			phase <= reload - 16'd1;
			if (WAVE == wave_square)
			begin
				sq_hi <= ~sq_hi;
			end
			else if (ramp_up)
			begin
				// turn around at the top
				ramp_up <= (ramp != 4'd14);
				ramp <= ramp + 1'b1;
			end
			else
			begin
				// and at the bottom
				ramp_up <= (ramp == 4'd1);
				ramp <= ramp - 1'b1;
			end
		end
		else
		begin
			phase <= phase - 16'd1;
		end
	end

	// square swings full scale, triangle follows the ramp
	always_comb
	begin
		if (!active)
			level = '0;
		else if (WAVE == wave_square)
			level = sq_hi ? 4'd15 : 4'd0;
		else
			level = ramp;
	end

endmodule

`default_nettype wire

// File: logic/channel_mixer.sv
`timescale 1ns/1ns
`default_nettype none

module channel_mixer (
	input wire logic clk,
	input wire logic rst,
	input wire synth_pkg::level_t lvl0,
	input wire synth_pkg::level_t lvl1,
	input wire synth_pkg::level_t lvl2,
	input wire logic [2:0] mute,
	input wire synth_pkg::vol_t vol,
	output synth_pkg::sample_t audio_out
);
	import synth_pkg::*;

	logic [8:0] sum;
	sample_t sat;

	// one channel after mute and volume
	// at most 120 at the top volume
	function automatic logic [8:0] scale(level_t lvl, logic muted, vol_t shift);
		logic [8:0] wide;
		wide = {5'b0, lvl};
		return muted ? 9'd0 : (wide << shift);
	endfunction

	// three channels fit in 9 bits
	assign sum = scale(lvl0, mute[0], vol) + scale(lvl1, mute[1], vol)
		+ scale(lvl2, mute[2], vol);
	// clip instead of wrapping
	assign sat = (sum > 9'd255) ? 8'hff : sum[7:0];

	always_ff @(posedge clk)
	begin
		if (rst)
			audio_out <= '0;
		else
			audio_out <= sat;
	end

endmodule

`default_nettype wire

// File: logic/chip_synth_top.sv
`timescale 1ns/1ns
`default_nettype none

module chip_synth_top (
	input wire logic clk,
	input wire logic rst,
	input wire logic run,
	input wire logic pause,
	input wire logic restart,
	input wire logic [2:0] mute,
	input wire synth_pkg::vol_t vol,
	output synth_pkg::sample_t audio_out,
	output seq_pkg::step_idx_t step_idx,
	output logic step_strobe
);
	import synth_pkg::*;
	import seq_pkg::*;

	logic tick;
	logic timer_en;
	logic timer_clear;
	step_rec_t step;
	level_t lvl_sq0;
	level_t lvl_sq1;
	level_t lvl_tri;

	tempo_timer u_timer (
		.clk   (clk),
		.rst   (rst),
		.en    (timer_en),
		.clear (timer_clear),
		.tick  (tick)
	);

	pattern_sequencer u_seq (
		.clk         (clk),
		.rst         (rst),
		.run         (run),
		.pause       (pause),
		.restart     (restart),
		.tick        (tick),
		.timer_en    (timer_en),
		.timer_clear (timer_clear),
		.step        (step),
		.step_idx    (step_idx),
		.step_strobe (step_strobe)
	);

	// lead and bass squares
	tone_channel #(.WAVE(wave_square)) u_sq0 (
		.clk   (clk),
		.rst   (rst),
		.cmd   (step.ch0),
		.level (lvl_sq0)
	);

	tone_channel #(.WAVE(wave_square)) u_sq1 (
		.clk   (clk),
		.rst   (rst),
		.cmd   (step.ch1),
		.level (lvl_sq1)
	);

	tone_channel #(.WAVE(wave_triangle)) u_tri (
		.clk   (clk),
		.rst   (rst),
		.cmd   (step.ch2),
		.level (lvl_tri)
	);

	channel_mixer u_mix (
		.clk       (clk),
		.rst       (rst),
		.lvl0      (lvl_sq0),
		.lvl1      (lvl_sq1),
		.lvl2      (lvl_tri),
		.mute      (mute),
		.vol       (vol),
		.audio_out (audio_out)
	);

endmodule

`default_nettype wire

// File: verif/synth_clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module synth_clock_gen (
	output logic clk,
	output logic rst
);
	localparam int HALF_PERIOD = 4;
	localparam int RESET_CYCLES = 5;

	// free running 8 ns clock
	initial
	begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = ~clk;
	end

	// reset held for a few edges, released just after one
	initial
	begin
		rst = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		#1 rst = 1'b0;
	end

endmodule

`default_nettype wire

// File: verif/chip_synth_tb.sv
`timescale 1ns/1ns
`default_nettype none

module chip_synth_tb;
	import synth_pkg::*;
	import seq_pkg::*;

	// lead notes of the pattern
	// odd steps rest
	localparam note_t LEAD_NOTES [NUM_STEPS] = '{
		6'd41, 6'd0, 6'd46, 6'd0, 6'd44, 6'd0, 6'd37, 6'd0,
		6'd37, 6'd0, 6'd39, 6'd0, 6'd39, 6'd0, 6'd51, 6'd0
	};

	logic clk;
	logic rst;
	logic run;
	logic pause;
	logic restart;
	logic [2:0] mute;
	vol_t vol;
	sample_t audio_out;
	step_idx_t step_idx;
	logic step_strobe;
	int seed;

	synth_clock_gen u_clk (
		.clk (clk),
		.rst (rst)
	);

	chip_synth_top u_dut (
		.clk         (clk),
		.rst         (rst),
		.run         (run),
		.pause       (pause),
		.restart     (restart),
		.mute        (mute),
		.vol         (vol),
		.audio_out   (audio_out),
		.step_idx    (step_idx),
		.step_strobe (step_strobe)
	);

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("sim failed");
		$fatal(1);
	endtask

	// drive and sample 1 ns after the edge
	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic check_sample(input string test, input sample_t exp, input sample_t act);
		if (exp !== act)
			abort_run($sformatf("Fail %s: expected %0d, actual %0d", test, exp, act));
	endtask

	task automatic check_idx(input string test, input step_idx_t exp, input step_idx_t act);
		if (exp !== act)
			abort_run($sformatf("Fail %s: expected %0d, actual %0d", test, exp, act));
	endtask

	task automatic check_count(input string test, input int exp, input int act);
		if (exp != act)
			abort_run($sformatf("Fail %s: expected %0d, actual %0d", test, exp, act));
	endtask

	// cycles until the next step strobe
	task automatic wait_strobe(input string test, input int limit, output int waited);
		int n;
		n = 0;
		do
		begin
			next_cycle();
			n++;
		end while (!step_strobe && n < limit);
		if (!step_strobe)
			abort_run($sformatf("%s: no step strobe within %0d cycles", test, limit));
		waited = n;
	endtask

	// cycles until audio_out moves away from its present value
	task automatic wait_audio_change(input string test, input int limit, output int waited);
		sample_t prev;
		int n;
		prev = audio_out;
		n = 0;
		do
		begin
			next_cycle();
			n++;
		end while (audio_out === prev && n < limit);
		if (audio_out === prev)
			abort_run($sformatf("%s: audio output did not change within %0d cycles", test, limit));
		waited = n;
	endtask

	task automatic wait_reset_release();
		int n;
		n = 0;
		while (rst !== 1'b0 && n < 64)
		begin
			next_cycle();
			n++;
		end
		if (rst !== 1'b0)
			abort_run("reset never released");
	endtask

	// idle outputs with run low
	task automatic test_reset_idle();
		int i;
		for (i = 0; i < 50; i++)
		begin
			next_cycle();
			check_sample("reset_idle", 8'd0, audio_out);
			check_idx("reset_idle", 4'd0, step_idx);
			if (step_strobe !== 1'b0)
				abort_run("reset_idle: step strobe pulsed while run was low");
		end
	endtask

	// strobe spacing and index order with a wrap
	task automatic test_step_order();
		int k;
		int waited;
		run = 1'b1;
		wait_strobe("step_order", 16, waited);
		check_idx("step_order", 4'd0, step_idx);
		for (k = 1; k <= NUM_STEPS + 1; k++)
		begin
			wait_strobe("step_order", STEP_TICKS + 16, waited);
			check_count("step_order spacing", STEP_TICKS, waited);
			check_idx("step_order", step_idx_t'(k % NUM_STEPS), step_idx);
		end
	endtask

	// lead square pitch on step 0 and silence on step 1
	task automatic test_square_pitch();
		int hp;
		int waited;
		int i;
		mute = 3'b110;
		vol = 2'd0;
		repeat (4) next_cycle();
		restart = 1'b1;
		next_cycle();
		restart = 1'b0;
		if (!step_strobe)
			abort_run("square_pitch: restart gave no step strobe");
		check_idx("square_pitch", 4'd0, step_idx);
		hp = note_half_period(LEAD_NOTES[0]);
		wait_audio_change("square_pitch", 2 * hp + 16, waited);
		check_sample("square_pitch rise", 8'd15, audio_out);
		wait_audio_change("square_pitch", hp + 4, waited);
		check_count("square_pitch half period", hp, waited);
		check_sample("square_pitch fall", 8'd0, audio_out);
		wait_audio_change("square_pitch", hp + 4, waited);
		check_count("square_pitch half period", hp, waited);
		check_sample("square_pitch rise", 8'd15, audio_out);
		wait_strobe("square_pitch", STEP_TICKS + 16, waited);
		check_idx("square_pitch", 4'd1, step_idx);
		// gate off plus one mixer cycle
		repeat (2) next_cycle();
		for (i = 0; i < 200; i++)
		begin
			check_sample("square_pitch odd step", 8'd0, audio_out);
			next_cycle();
		end
	endtask

	// triangle sweeps the full scaled range
	task automatic test_triangle_peak();
		int peak;
		int n;
		logic seen_low;
		logic seen_high;
		mute = 3'b011;
		vol = vol_t'($random(seed));
		peak = 15 << vol;
		seen_low = 1'b0;
		seen_high = 1'b0;
		n = 0;
		repeat (2) next_cycle();
		while (!(seen_low && seen_high) && n < 3 * STEP_TICKS)
		begin
			next_cycle();
			n++;
			if (audio_out > peak)
				check_sample("triangle_peak ceiling", sample_t'(peak), audio_out);
			if (audio_out == 8'd0)
				seen_low = 1'b1;
			if (audio_out == peak)
				seen_high = 1'b1;
		end
		if (!(seen_low && seen_high))
			abort_run($sformatf("triangle_peak: range 0..%0d not covered in time", peak));
	endtask

	// pause freezes the index and release resumes with the next one
	task automatic test_pause_hold();
		step_idx_t held;
		int waited;
		int i;
		wait_strobe("pause_hold", STEP_TICKS + 16, waited);
		held = step_idx;
		pause = 1'b1;
		for (i = 0; i < STEP_TICKS + 256; i++)
		begin
			next_cycle();
			if (step_strobe)
				abort_run("pause_hold: step strobe while paused");
			check_idx("pause_hold", held, step_idx);
		end
		pause = 1'b0;
		wait_strobe("pause_hold", STEP_TICKS + 16, waited);
		check_idx("pause_hold resume", held + 1'b1, step_idx);
	endtask

	// restart mid step then full mix into saturation
	task automatic test_restart_mix();
		int n;
		logic seen_max;
		repeat (300) next_cycle();
		restart = 1'b1;
		next_cycle();
		restart = 1'b0;
		if (!step_strobe)
			abort_run("restart_mix: restart gave no step strobe");
		check_idx("restart_mix", 4'd0, step_idx);
		mute = 3'b000;
		vol = 2'd3;
		seen_max = 1'b0;
		n = 0;
		while (!seen_max && n < 4 * STEP_TICKS)
		begin
			next_cycle();
			n++;
			if ($isunknown(audio_out))
				abort_run("restart_mix: audio output is unknown");
			if (audio_out == 8'd255)
				seen_max = 1'b1;
		end
		if (!seen_max)
			abort_run("restart_mix: full mix never reached saturation");
	endtask

	initial
	begin
		seed = 32'h9b4f5948;
		run = 1'b0;
		pause = 1'b0;
		restart = 1'b0;
		mute = 3'b111;
		vol = 2'd0;
		wait_reset_release();
		test_reset_idle();
		test_step_order();
		test_square_pitch();
		test_triangle_peak();
		test_pause_hold();
		test_restart_mix();
		$display("sim passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: files.f
logic/synth_pkg.sv
logic/seq_pkg.sv
logic/tempo_timer.sv
logic/pattern_sequencer.sv
logic/tone_channel.sv
logic/channel_mixer.sv
logic/chip_synth_top.sv
verif/synth_clock_gen.sv
verif/chip_synth_tb.sv

// File: Bender.yml
package:
  name: chip_synth

sources:
  - logic/synth_pkg.sv
  - logic/seq_pkg.sv
  - logic/tempo_timer.sv
  - logic/pattern_sequencer.sv
  - logic/tone_channel.sv
  - logic/channel_mixer.sv
  - logic/chip_synth_top.sv
  - target: simulation
    files:
      - verif/synth_clock_gen.sv
      - verif/chip_synth_tb.sv
